//--- hdl/mcu_pkg.sv
//----------------------------------------------------------------------
// MCU I/O package
// Widths, vector types, register map and FSM states of the I/O fabric
//----------------------------------------------------------------------
package mcu_pkg;

  localparam int CELL_W = 18;                    // CPU data cell
  typedef logic [CELL_W-1:0] cell_t;

  localparam int IOA_W = 2;                      // I/O register address
  typedef logic [IOA_W-1:0] ioa_t;

  typedef logic [7:0] byte_t;                    // UART character

  localparam int DIV_W = 16;                     // Bit period in clocks
  typedef logic [DIV_W-1:0] div_t;
  typedef logic [15:0] cyc_t;                    // Free-running counter

  localparam div_t RST_DIV = 16'd32;             // Divisor out of reset

  localparam int IRQ_N = 4;                      // Slot 0 means no request
  typedef logic [$clog2(IRQ_N)-1:0] vec_t;
  localparam vec_t IRQ_CYC = 2'd1;               // Counter wrap
  localparam vec_t IRQ_TX  = 2'd2;               // Transmitter ready again
  localparam vec_t IRQ_RX  = 2'd3;               // Byte received, top priority

  localparam ioa_t A_DATA = 2'd0;                // UART data
  localparam ioa_t A_STAT = 2'd1;                // UART status
  localparam ioa_t A_CYC  = 2'd2;                // Cycle counter
  localparam ioa_t A_DIV  = 2'd3;                // Bit divisor

  typedef enum logic [1:0] {
    TX_IDLE, TX_START, TX_DATA, TX_STOP
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE, RX_START, RX_DATA, RX_STOP
  } rx_state_t;

endpackage

//--- hdl/baud_timer.sv
//----------------------------------------------------------------------
// Baud timer
// Down-counter that ticks once per bit period after a start pulse,
// with an optional half-period first interval
//----------------------------------------------------------------------
`timescale 1ns/1ps

module baud_timer (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start_i,                 // Restart the interval
  input  logic          half_i,                  // First interval is half
  input  mcu_pkg::div_t period_i,                // Bit period in clocks
  output logic          tick_o                   // One cycle per interval
);

  mcu_pkg::div_t cnt_q;
  mcu_pkg::div_t first;                          // Length of first interval

  assign first  = half_i ? (period_i >> 1) : period_i;
  assign tick_o = (cnt_q == '0);                 // Expired this cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= first - 1'b1;                     // Edge after start counts as 1
    end else if (tick_o) begin
      cnt_q <= period_i - 1'b1;                  // Keep ticking at full rate
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Shorter periods leave no room for the half-bit start check
  a_period_min: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> (period_i >= 16'd4));

endmodule

//--- hdl/uart_tx.sv
//----------------------------------------------------------------------
// UART transmitter
// Sends one byte as an 8N1 frame on txd, one bit per timer tick
//----------------------------------------------------------------------
`timescale 1ns/1ps

module uart_tx (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wr_i,                   // Only issued while ready
  input  mcu_pkg::byte_t byte_i,
  input  mcu_pkg::div_t  div_i,
  output logic           ready_o,
  output logic           txd_o
);

  mcu_pkg::tx_state_t state_q;
  mcu_pkg::byte_t     shift_q;                   // LSB is next data bit
  logic [2:0]         bit_q;                     // Data bit index
  logic               txd_q;
  logic               ready_q;
  logic               tick;

  assign txd_o   = txd_q;
  assign ready_o = ready_q;

  baud_timer bt_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (wr_i),                            // Start bit begins now
    .half_i   (1'b0),
    .period_i (div_i),
    .tick_o   (tick)
  );

  always_ff @(posedge clk) begin
    if (wr_i) shift_q <= byte_i;
    else if (tick && state_q == mcu_pkg::TX_DATA) shift_q <= shift_q >> 1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mcu_pkg::TX_IDLE;
      bit_q   <= '0;
      txd_q   <= 1'b1;                           // Line idles high
      ready_q <= 1'b1;
    end else begin
      case (state_q)
        mcu_pkg::TX_IDLE: if (wr_i) begin
          state_q <= mcu_pkg::TX_START;
          txd_q   <= 1'b0;                       // Start bit
          ready_q <= 1'b0;
          bit_q   <= '0;
        end
        mcu_pkg::TX_START: if (tick) begin
          state_q <= mcu_pkg::TX_DATA;
          txd_q   <= shift_q[0];
        end
        mcu_pkg::TX_DATA: if (tick) begin
          bit_q <= bit_q + 1'b1;
          if (bit_q == 3'd7) begin
            state_q <= mcu_pkg::TX_STOP;
            txd_q   <= 1'b1;                     // Stop bit
          end else begin
            txd_q <= shift_q[1];                 // Shift happens on same edge
          end
        end
        default: if (tick) begin                 // TX_STOP
          state_q <= mcu_pkg::TX_IDLE;
          ready_q <= 1'b1;
        end
      endcase
    end
  end

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == mcu_pkg::TX_IDLE) |-> txd_o);
  a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
    ready_o == (state_q == mcu_pkg::TX_IDLE));

endmodule

//--- hdl/uart_rx.sv
//----------------------------------------------------------------------
// UART receiver
// Synchronises rxd, checks the start bit at half period and samples
// 8N1 frames mid-bit into a one-byte holding register
//----------------------------------------------------------------------
`timescale 1ns/1ps

module uart_rx (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           rxd_i,                  // Asynchronous line
  input  mcu_pkg::div_t  div_i,
  input  logic           pop_i,                  // CPU read of the data
  output logic           full_o,
  output logic           ovr_o,
  output mcu_pkg::byte_t byte_o
);

  mcu_pkg::rx_state_t state_q;
  mcu_pkg::byte_t     shift_q;                   // Bits arrive LSB first
  mcu_pkg::byte_t     byte_q;
  logic [2:0]         bit_q;
  logic               rxd_m, rxd_s, rxd_d;       // Two-flop sync plus history
  logic               full_q, ovr_q;
  logic               fall, start, tick, store;

  assign fall   = rxd_d & ~rxd_s;
  assign start  = fall && (state_q == mcu_pkg::RX_IDLE);
  assign store  = tick && (state_q == mcu_pkg::RX_STOP) && rxd_s;  // Good stop bit
  assign full_o = full_q;
  assign ovr_o  = ovr_q;
  assign byte_o = byte_q;

  baud_timer bt_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (start),
    .half_i   (1'b1),                            // Land in middle of start bit
    .period_i (div_i),
    .tick_o   (tick)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rxd_m <= 1'b1;
      rxd_s <= 1'b1;
      rxd_d <= 1'b1;
    end else begin
      rxd_m <= rxd_i;
      rxd_s <= rxd_m;
      rxd_d <= rxd_s;
    end
  end

  always_ff @(posedge clk) begin
    if (tick && state_q == mcu_pkg::RX_DATA) shift_q <= {rxd_s, shift_q[7:1]};
    if (store) byte_q <= shift_q;                // Newest byte always wins
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mcu_pkg::RX_IDLE;
      bit_q   <= '0;
    end else begin
      case (state_q)
        mcu_pkg::RX_IDLE: if (start) state_q <= mcu_pkg::RX_START;
        mcu_pkg::RX_START: if (tick) begin
          state_q <= rxd_s ? mcu_pkg::RX_IDLE : mcu_pkg::RX_DATA;  // Glitch rejected
          bit_q   <= '0;
        end
        mcu_pkg::RX_DATA: if (tick) begin
          bit_q <= bit_q + 1'b1;
          if (bit_q == 3'd7) state_q <= mcu_pkg::RX_STOP;
        end
        default: if (tick) state_q <= mcu_pkg::RX_IDLE;  // Low stop drops frame
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      ovr_q  <= 1'b0;
    end else if (store) begin
      full_q <= 1'b1;
      ovr_q  <= full_q & ~pop_i;                 // Old byte was never read
    end else if (pop_i) begin
      full_q <= 1'b0;
      ovr_q  <= 1'b0;
    end
  end

  a_ovr_full: assert property (@(posedge clk) disable iff (!rst_n)
    ovr_o |-> full_o);

endmodule

//--- hdl/irq_ctrl.sv
//----------------------------------------------------------------------
// Interrupt controller
// Latches event strobes, registers the highest pending vector and
// clears the named source on acknowledge
//----------------------------------------------------------------------
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [mcu_pkg::IRQ_N-1:0] ev_i,        // Bit 0 has no source
  input  logic                      iack_i,
  output logic                      irq_o,
  output mcu_pkg::vec_t             ivec_o
);

  logic [mcu_pkg::IRQ_N-1:0] pend_q;
  logic [mcu_pkg::IRQ_N-1:0] ev_m;
  logic [mcu_pkg::IRQ_N-1:0] clr;
  mcu_pkg::vec_t             top;                // Winner from pending bits
  mcu_pkg::vec_t             ivec_q;

  assign ev_m   = {ev_i[mcu_pkg::IRQ_N-1:1], 1'b0};
  assign irq_o  = (ivec_q != '0);
  assign ivec_o = ivec_q;

  // Highest index wins
  always_comb begin
    top = '0;
    for (int i = 1; i < mcu_pkg::IRQ_N; i++) begin
      if (pend_q[i]) top = mcu_pkg::vec_t'(i);
    end
  end

  always_comb begin
    clr = '0;
    if (iack_i) clr[ivec_q] = 1'b1;              // Source the CPU is serving
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= '0;
      ivec_q <= '0;
    end else begin
      pend_q <= (pend_q & ~clr) | ev_m;          // Fresh event survives ack
      ivec_q <= top;                             // Lags pending by one cycle
    end
  end

  a_iack_irq: assert property (@(posedge clk) disable iff (!rst_n)
    iack_i |-> irq_o);

endmodule

//--- hdl/io_regs.sv
//----------------------------------------------------------------------
// I/O register block
// Decodes CPU strobes, holds divisor and cycle counter, and forms
// the interrupt event strobes
//----------------------------------------------------------------------
`timescale 1ns/1ps

module io_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      io_rd_i,
  input  logic                      io_wr_i,
  input  mcu_pkg::ioa_t             io_addr_i,
  input  mcu_pkg::cell_t            io_din_i,
  output mcu_pkg::cell_t            io_dout_o,
  input  logic                      tx_ready_i,
  input  logic                      rx_full_i,
  input  logic                      rx_ovr_i,
  input  mcu_pkg::byte_t            rx_byte_i,
  output logic                      tx_wr_o,
  output mcu_pkg::byte_t            tx_byte_o,
  output logic                      rx_pop_o,
  output mcu_pkg::div_t             div_o,
  output logic [mcu_pkg::IRQ_N-1:0] ev_o
);

  mcu_pkg::div_t             div_q;
  mcu_pkg::cyc_t             cyc_q;
  logic                      ready_d, full_d;    // Previous levels for edges
  logic [mcu_pkg::IRQ_N-1:0] ev_q;
  logic                      wr_data, wr_div;

  assign wr_data   = io_wr_i && (io_addr_i == mcu_pkg::A_DATA);
  assign wr_div    = io_wr_i && (io_addr_i == mcu_pkg::A_DIV);
  assign tx_wr_o   = wr_data && tx_ready_i;      // Busy writes are dropped
  assign tx_byte_o = io_din_i[7:0];
  assign rx_pop_o  = io_rd_i && (io_addr_i == mcu_pkg::A_DATA);
  assign div_o     = div_q;
  assign ev_o      = ev_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_q <= mcu_pkg::RST_DIV;
      cyc_q <= '0;
    end else begin
      cyc_q <= cyc_q + 1'b1;                     // Wraps at 2^16
      if (wr_div) div_q <= io_din_i[mcu_pkg::DIV_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_d <= 1'b1;                           // Ready out of reset, no event
      full_d  <= 1'b0;
      ev_q    <= '0;
    end else begin
      ready_d              <= tx_ready_i;
      full_d               <= rx_full_i;
      ev_q                 <= '0;
      ev_q[mcu_pkg::IRQ_CYC] <= (cyc_q == '1);   // Counter about to wrap
      ev_q[mcu_pkg::IRQ_TX]  <= tx_ready_i & ~ready_d;
      ev_q[mcu_pkg::IRQ_RX]  <= rx_full_i & ~full_d;
    end
  end

  // Read mux, zero-extended to the cell
  always_comb begin
    case (io_addr_i)
      mcu_pkg::A_DATA: io_dout_o = mcu_pkg::cell_t'(rx_byte_i);
      mcu_pkg::A_STAT: io_dout_o = mcu_pkg::cell_t'({rx_ovr_i, rx_full_i, tx_ready_i});
      mcu_pkg::A_CYC:  io_dout_o = mcu_pkg::cell_t'(cyc_q);
      default:         io_dout_o = mcu_pkg::cell_t'(div_q);
    endcase
  end

endmodule

//--- hdl/mcu_io.sv
//----------------------------------------------------------------------
// MCU I/O fabric top
// Register block, UART halves and interrupt controller
//----------------------------------------------------------------------
`timescale 1ns/1ps

module mcu_io (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           io_rd_i,                // CPU read strobe
  input  logic           io_wr_i,                // CPU write strobe
  input  mcu_pkg::ioa_t  io_addr_i,
  input  mcu_pkg::cell_t io_din_i,
  output mcu_pkg::cell_t io_dout_o,
  input  logic           iack_i,
  output logic           irq_o,
  output mcu_pkg::vec_t  ivec_o,
  input  logic           rxd_i,                  // Async serial in
  output logic           txd_o
);

  logic                      tx_wr;
  mcu_pkg::byte_t            tx_byte;
  logic                      tx_ready;
  logic                      rx_pop;
  logic                      rx_full;
  logic                      rx_ovr;
  mcu_pkg::byte_t            rx_byte;
  mcu_pkg::div_t             div;                // Shared by both UART halves
  logic [mcu_pkg::IRQ_N-1:0] ev;

  io_regs io_regs_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .io_rd_i    (io_rd_i),
    .io_wr_i    (io_wr_i),
    .io_addr_i  (io_addr_i),
    .io_din_i   (io_din_i),
    .io_dout_o  (io_dout_o),
    .tx_ready_i (tx_ready),
    .rx_full_i  (rx_full),
    .rx_ovr_i   (rx_ovr),
    .rx_byte_i  (rx_byte),
    .tx_wr_o    (tx_wr),
    .tx_byte_o  (tx_byte),
    .rx_pop_o   (rx_pop),
    .div_o      (div),
    .ev_o       (ev)
  );

  uart_tx uart_tx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (tx_wr),
    .byte_i  (tx_byte),
    .div_i   (div),
    .ready_o (tx_ready),
    .txd_o   (txd_o)
  );

  uart_rx uart_rx_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .rxd_i  (rxd_i),
    .div_i  (div),
    .pop_i  (rx_pop),
    .full_o (rx_full),
    .ovr_o  (rx_ovr),
    .byte_o (rx_byte)
  );

  irq_ctrl irq_ctrl_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .ev_i   (ev),
    .iack_i (iack_i),
    .irq_o  (irq_o),
    .ivec_o (ivec_o)
  );

endmodule

//--- bench/tb_mcu_io.sv
//----------------------------------------------------------------------
// MCU I/O testbench
// Plays the CPU on the I/O strobes and models the serial line
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_mcu_io;

  localparam int LOOP_BYTES   = 4;                // Bytes per loopback divisor
  localparam int FRAME_CYC    = 10 * 8 * 6 + 10 * (4 + 7 + 16) * LOOP_BYTES;
  localparam int WATCHDOG_CYC = FRAME_CYC + 70000 + 10000;  // Frames, wrap, margin

  logic           clk = 1'b0;
  logic           rst_n, io_rd_i, io_wr_i, iack_i, irq_o, txd_o;
  logic           rxd_i = 1'b1;
  mcu_pkg::ioa_t  io_addr_i;
  mcu_pkg::cell_t io_din_i, io_dout_o;
  mcu_pkg::vec_t  ivec_o;
  logic           ser_line = 1'b1;               // Serial model output
  logic           loop_en = 1'b0;                // Feed txd back into rxd
  mcu_pkg::div_t  tb_div;                        // Divisor as programmed here
  int unsigned    tb_cyc, read_cyc;
  int             checks, errors;
  string          test_name = "startup";

  mcu_io mcu_io_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .io_rd_i   (io_rd_i),
    .io_wr_i   (io_wr_i),
    .io_addr_i (io_addr_i),
    .io_din_i  (io_din_i),
    .io_dout_o (io_dout_o),
    .iack_i    (iack_i),
    .irq_o     (irq_o),
    .ivec_o    (ivec_o),
    .rxd_i     (rxd_i),
    .txd_o     (txd_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    tb_cyc <= tb_cyc + 1;                        // Reference cycle count
    rxd_i  <= loop_en ? txd_o : ser_line;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error: time %0t signal %s expected 0x%0h actual 0x%0h",
               $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure at %0t in %s: %s", $time, test_name, what);
  endtask

  task automatic log_test_end(input int err_before);
    $display("test %s finished, %0d errors", test_name, errors - err_before);
  endtask

  task automatic io_write(input mcu_pkg::ioa_t addr, input mcu_pkg::cell_t data);
    @(posedge clk);
    io_wr_i   <= 1'b1;
    io_addr_i <= addr;
    io_din_i  <= data;
    @(posedge clk);                              // DUT takes the write here
    io_wr_i <= 1'b0;
  endtask

  task automatic io_read(input mcu_pkg::ioa_t addr, output mcu_pkg::cell_t data);
    @(posedge clk);
    io_rd_i   <= 1'b1;
    io_addr_i <= addr;
    @(negedge clk);
    data     = io_dout_o;                        // Combinational, stable mid-cycle
    read_cyc = tb_cyc;
    @(posedge clk);                              // Pop edge for A_DATA
    io_rd_i <= 1'b0;
  endtask

  task automatic set_divisor(input mcu_pkg::div_t d);
    io_write(mcu_pkg::A_DIV, mcu_pkg::cell_t'(d));
    tb_div = d;
  endtask

  task automatic wait_status(input logic [2:0] mask, input logic [2:0] value,
                             input string what);
    mcu_pkg::cell_t st;
    int polls;
    polls = 0;
    do begin
      io_read(mcu_pkg::A_STAT, st);
      polls++;
    end while (((st[2:0] & mask) != value) && (polls < 20 * tb_div));
    if ((st[2:0] & mask) != value) report_failure({"status never showed ", what});
  endtask

  // Waits for a request whose vector differs from old_vec
  task automatic wait_vector(input mcu_pkg::vec_t old_vec, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(irq_o && ivec_o != old_vec) && (n < limit));
    if (!(irq_o && ivec_o != old_vec)) report_failure("interrupt request never arrived");
  endtask

  task automatic acknowledge();
    @(negedge clk);
    if (!irq_o) begin
      report_failure("acknowledge wanted but no interrupt is raised");
    end else begin
      @(posedge clk) iack_i <= 1'b1;
      @(posedge clk) iack_i <= 1'b0;             // Pending cleared here
      @(posedge clk);                            // Vector follows one cycle later
      @(negedge clk);
    end
  endtask

  task automatic drive_bit(input logic b);
    @(posedge clk) ser_line <= b;
    repeat (tb_div - 1) @(posedge clk);          // Hold for one bit period
  endtask

  task automatic send_serial(input mcu_pkg::byte_t data, input logic stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);                        // LSB first
    end
    drive_bit(stop);
    drive_bit(1'b1);                             // Idle gap, also ends a bad frame
  endtask

  task automatic recv_serial(output mcu_pkg::byte_t data);
    int n;
    n = 0;
    data = '0;
    do begin
      @(negedge clk);
      n++;
    end while (txd_o && (n < 20 * tb_div));
    if (txd_o) begin
      report_failure("no start bit seen on txd_o");
    end else begin
      repeat (tb_div / 2) @(negedge clk);        // Middle of start bit
      check("txd_o start", 0, txd_o);
      for (int i = 0; i < 8; i++) begin
        repeat (tb_div) @(negedge clk);
        data[i] = txd_o;
      end
      repeat (tb_div) @(negedge clk);
      check("txd_o stop", 1, txd_o);
    end
  endtask

  task automatic reset_state();
    mcu_pkg::cell_t v, c0, c1;
    int unsigned    t0;
    int             err0;
    err0      = errors;
    test_name = "reset state";
    @(negedge clk);
    check("txd_o", 1, txd_o);
    check("irq_o", 0, irq_o);
    check("ivec_o", 0, ivec_o);
    io_read(mcu_pkg::A_STAT, v);
    check("status", 3'b001, v);
    io_read(mcu_pkg::A_DIV, v);
    check("divisor", mcu_pkg::RST_DIV, v);
    io_read(mcu_pkg::A_CYC, c0);
    t0 = read_cyc;
    repeat ($urandom_range(40, 3)) @(posedge clk);
    io_read(mcu_pkg::A_CYC, c1);
    check("cycle delta", mcu_pkg::cyc_t'(read_cyc - t0), mcu_pkg::cyc_t'(c1 - c0));
    log_test_end(err0);
  endtask

  task automatic transmit_byte();
    mcu_pkg::byte_t b, got;
    mcu_pkg::cell_t v;
    int             err0;
    err0      = errors;
    test_name = "transmit";
    set_divisor(16'd8);
    io_read(mcu_pkg::A_DIV, v);
    check("divisor", 8, v);
    b = mcu_pkg::byte_t'($urandom);
    io_write(mcu_pkg::A_DATA, mcu_pkg::cell_t'(b));
    fork
      recv_serial(got);
      begin
        io_read(mcu_pkg::A_STAT, v);
        check("tx ready in frame", 0, v[0]);
      end
    join
    check("txd_o byte", b, got);
    wait_vector('0, 4 * tb_div);                 // Ready rises after stop bit
    check("ivec_o", mcu_pkg::IRQ_TX, ivec_o);
    acknowledge();
    check("irq_o after ack", 0, irq_o);
    log_test_end(err0);
  endtask

  task automatic receive_byte();
    mcu_pkg::byte_t b;
    mcu_pkg::cell_t v;
    int             err0;
    err0      = errors;
    test_name = "receive";
    b = mcu_pkg::byte_t'($urandom);
    send_serial(b, 1'b1);
    wait_status(3'b010, 3'b010, "rx full");
    wait_vector('0, 4 * tb_div);
    check("ivec_o", mcu_pkg::IRQ_RX, ivec_o);
    io_read(mcu_pkg::A_DATA, v);
    check("rx byte", b, v);
    acknowledge();
    check("irq_o after ack", 0, irq_o);
    io_read(mcu_pkg::A_STAT, v);
    check("status", 3'b001, v);                  // Read popped the byte
    log_test_end(err0);
  endtask

  task automatic overrun_and_framing();
    mcu_pkg::byte_t a, b, c;
    mcu_pkg::cell_t v;
    int             err0;
    err0      = errors;
    test_name = "overrun and framing";
    a = mcu_pkg::byte_t'($urandom);
    b = mcu_pkg::byte_t'($urandom);
    c = mcu_pkg::byte_t'($urandom);
    send_serial(a, 1'b1);
    send_serial(b, 1'b1);                        // Second byte with no read between
    wait_status(3'b100, 3'b100, "rx overrun");
    io_read(mcu_pkg::A_STAT, v);
    check("status", 3'b111, v);
    wait_vector('0, 4 * tb_div);
    check("ivec_o", mcu_pkg::IRQ_RX, ivec_o);
    acknowledge();
    io_read(mcu_pkg::A_DATA, v);
    check("rx byte", b, v);                      // Newest byte kept
    io_read(mcu_pkg::A_STAT, v);
    check("status", 3'b001, v);
    send_serial(c, 1'b0);                        // Broken stop bit
    repeat (2 * tb_div) @(posedge clk);
    @(negedge clk);
    check("irq_o", 0, irq_o);
    io_read(mcu_pkg::A_STAT, v);
    check("status", 3'b001, v);
    log_test_end(err0);
  endtask

  task automatic priority_and_wrap();
    mcu_pkg::byte_t b;
    mcu_pkg::cell_t v;
    int             err0;
    err0      = errors;
    test_name = "priority and wrap";
    wait_vector('0, 70000);                      // Counter wrap
    check("ivec_o", mcu_pkg::IRQ_CYC, ivec_o);
    io_read(mcu_pkg::A_CYC, v);
    check("counter just wrapped", 1, v < 16);
    b = mcu_pkg::byte_t'($urandom);
    send_serial(b, 1'b1);
    wait_vector(mcu_pkg::IRQ_CYC, 4 * tb_div);
    check("ivec_o", mcu_pkg::IRQ_RX, ivec_o);    // Receiver outranks counter
    io_read(mcu_pkg::A_DATA, v);
    check("rx byte", b, v);
    acknowledge();
    check("ivec_o", mcu_pkg::IRQ_CYC, ivec_o);
    acknowledge();
    check("irq_o", 0, irq_o);
    log_test_end(err0);
  endtask

  task automatic loopback_divisors();
    int             divs[3];
    mcu_pkg::byte_t b;
    mcu_pkg::cell_t v;
    int             err0;
    err0      = errors;
    test_name = "loopback";
    divs      = '{4, 7, 16};
    @(negedge clk);
    loop_en = 1'b1;
    foreach (divs[k]) begin
      set_divisor(mcu_pkg::div_t'(divs[k]));
      for (int n = 0; n < LOOP_BYTES; n++) begin
        b = mcu_pkg::byte_t'($urandom);
        io_write(mcu_pkg::A_DATA, mcu_pkg::cell_t'(b));
        wait_status(3'b011, 3'b011, "rx full with tx ready");
        io_read(mcu_pkg::A_DATA, v);
        check("loopback byte", b, v);
      end
    end
    log_test_end(err0);
  endtask

  initial begin
    void'($urandom(10));
    rst_n     = 1'b0;
    io_rd_i   = 1'b0;
    io_wr_i   = 1'b0;
    iack_i    = 1'b0;
    io_addr_i = '0;
    io_din_i  = '0;
    tb_div    = mcu_pkg::RST_DIV;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    reset_state();
    transmit_byte();
    receive_byte();
    overrun_and_framing();
    priority_and_wrap();
    loopback_divisors();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("timeout: test %s did not finish within %0d cycles", test_name, WATCHDOG_CYC);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- files.f
hdl/mcu_pkg.sv
hdl/baud_timer.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/irq_ctrl.sv
hdl/io_regs.sv
hdl/mcu_io.sv
bench/tb_mcu_io.sv
